/* files.f */
+incdir+hdl
hdl/wbuf_pkg.sv
hdl/rr_arbiter.sv
hdl/rtrn_fifo.sv
hdl/tx_former.sv
hdl/tx_tracker.sv
hdl/wbuf_store.sv
hdl/wbuf_top.sv
testbench/tb_clk_gen.sv
testbench/wbuf_checker.sv
testbench/tb_wbuf_monitor.sv
testbench/tb_wbuf.sv

/* hdl/rr_arbiter.sv */
// needs num_in of 2 or more; a locked choice is dropped if its own request goes away
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int unsigned num_in = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [num_in-1:0]         req_i,
  input  logic                      gnt_i,
  output logic [$clog2(num_in)-1:0] idx_o
);

  localparam int unsigned idx_w = $clog2(num_in);

  logic [idx_w-1:0] last_q;
  logic [idx_w-1:0] lock_idx_q;
  logic             lock_q;
  logic [idx_w-1:0] pick;
  logic             locked;

  // first request after the last granted index, that index itself last
  always_comb begin : p_pick
    int unsigned cand;
    pick = last_q;
    for (int unsigned i = num_in; i >= 1; i--) begin
      cand = (int'(last_q) + i) % num_in;
      if (req_i[cand]) begin
        pick = idx_w'(cand);
      end
    end
  end

  // hold the previous choice until it is granted
  assign locked = lock_q && req_i[lock_idx_q];
  assign idx_o  = locked ? lock_idx_q : pick;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      // index 0 wins first after reset
      last_q     <= idx_w'(num_in - 1);
      lock_idx_q <= '0;
      lock_q     <= 1'b0;
    end else begin
      lock_q     <= (|req_i) && !gnt_i;
      lock_idx_q <= idx_o;
      if (gnt_i) begin
        last_q <= idx_o;
      end
    end
  end

endmodule

/* hdl/rtrn_fifo.sv */
// no full flag; pushes beyond the depth overwrite, so callers keep at most depth IDs in flight
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module rtrn_fifo (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  wbuf_pkg::tx_id_t  data_i,
  input  logic              pop_i,
  output wbuf_pkg::tx_id_t  data_o,
  output logic              empty_o
);
  import wbuf_pkg::*;

  localparam int unsigned depth = `WBUF_MAX_TX;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

  tx_id_t           mem_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w:0]   cnt_q;
  logic             do_pop;

  // a pop on an empty FIFO is ignored
  assign do_pop  = pop_i && (cnt_q != '0);
  assign empty_o = (cnt_q == '0);
  // registered head, no fall-through
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin : p_mem
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* hdl/tx_former.sv */
// purely combinational; outputs are meaningless while the entry has no sendable byte
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module tx_former (
  input  wbuf_pkg::wbuf_entry_t  entry_i,
  output logic [`WBUF_PLEN-1:0]  paddr_o,
  output wbuf_pkg::tx_size_t     size_o,
  output wbuf_pkg::word_data_t   wdata_o,
  output wbuf_pkg::byte_mask_t   be_o
);
  import wbuf_pkg::*;

  localparam int unsigned nbytes  = `WBUF_XLEN / 8;
  localparam int unsigned align_w = `WBUF_ALIGN_BITS;

  byte_mask_t         sendable;
  logic [align_w-1:0] off;

  // dirty bytes of a word with nothing in flight
  assign sendable = (|entry_i.txblock) ? '0 : (entry_i.dirty & entry_i.valid);

  // lowest sendable byte
  always_comb begin : p_offset
    off = '0;
    for (int b = nbytes - 1; b >= 0; b--) begin
      if (sendable[b]) begin
        off = align_w'(b);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // largest aligned size fully covered by sendable bytes
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_size
    if ((off == '0) && (&sendable)) begin
      size_o = SIZE_WORD;
    end else if (!off[0] && (&sendable[{off[1], 1'b0} +: 2])) begin
      size_o = SIZE_HALF;
    end else begin
      // holes and odd offsets go out one byte at a time
      size_o = SIZE_BYTE;
    end
  end

  // byte enables and data replicated over the bus
  always_comb begin : p_lanes
    be_o    = '0;
    wdata_o = entry_i.data;
    case (size_o)
      SIZE_BYTE: begin
        be_o[off] = 1'b1;
        for (int b = 0; b < nbytes; b++) begin
          wdata_o[b*8 +: 8] = entry_i.data[off*8 +: 8];
        end
      end
      SIZE_HALF: begin
        be_o[off +: 2] = 2'b11;
        for (int h = 0; h < nbytes / 2; h++) begin
          wdata_o[h*16 +: 16] = entry_i.data[off*8 +: 16];
        end
      end
      default: begin
        be_o = '1;
      end
    endcase
  end

  // byte address of the first byte sent
  assign paddr_o = {entry_i.wtag, off};

endmodule

/* hdl/tx_tracker.sv */
// one eviction per cycle; returned IDs must belong to open slots and come back once each
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module tx_tracker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // transfer accepted by memory
  input  logic                  send_i,
  input  wbuf_pkg::wbuf_ptr_t   send_ptr_i,
  input  wbuf_pkg::byte_mask_t  send_be_i,
  // returned IDs
  input  logic                  rtrn_vld_i,
  input  wbuf_pkg::tx_id_t      rtrn_id_i,
  // slot for the next transfer
  output logic                  slot_free_o,
  output wbuf_pkg::tx_id_t      tx_id_o,
  // bytes to release in the store
  output logic                  evict_o,
  output wbuf_pkg::wbuf_ptr_t   evict_ptr_o,
  output wbuf_pkg::byte_mask_t  evict_be_o
);
  import wbuf_pkg::*;

  tx_stat_t                tx_stat_q [`WBUF_MAX_TX];
  tx_stat_t                tx_stat_d [`WBUF_MAX_TX];
  logic [`WBUF_MAX_TX-1:0] slot_free;
  tx_id_t                  rtrn_id;
  logic                    rtrn_empty;

  for (genvar k = 0; k < `WBUF_MAX_TX; k++) begin : g_free
    assign slot_free[k] = !tx_stat_q[k].vld;
  end
  assign slot_free_o = |slot_free;

  //////////////////////////////////////////////////////////////////////
  // returned IDs and free-ID choice
  //////////////////////////////////////////////////////////////////////

  rtrn_fifo i_rtrn_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rtrn_vld_i),
    .data_i  (rtrn_id_i),
    .pop_i   (evict_o),
    .data_o  (rtrn_id),
    .empty_o (rtrn_empty)
  );

  // choice stays put until the transfer is accepted
  rr_arbiter #(
    .num_in (`WBUF_MAX_TX)
  ) i_id_rr (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (slot_free),
    .gnt_i  (send_i),
    .idx_o  (tx_id_o)
  );

  // head of the FIFO is evicted the cycle after it arrives
  assign evict_o     = !rtrn_empty;
  assign evict_ptr_o = tx_stat_q[rtrn_id].ptr;
  assign evict_be_o  = tx_stat_q[rtrn_id].be;

  // a returning slot is never the one being allocated, it is still valid
  always_comb begin : p_slots
    for (int k = 0; k < `WBUF_MAX_TX; k++) begin
      tx_stat_d[k] = tx_stat_q[k];
    end
    if (evict_o) begin
      tx_stat_d[rtrn_id].vld = 1'b0;
    end
    if (send_i) begin
      tx_stat_d[tx_id_o].vld = 1'b1;
      tx_stat_d[tx_id_o].be  = send_be_i;
      tx_stat_d[tx_id_o].ptr = send_ptr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      for (int k = 0; k < `WBUF_MAX_TX; k++) begin
        tx_stat_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < `WBUF_MAX_TX; k++) begin
        tx_stat_q[k] <= tx_stat_d[k];
      end
    end
  end

endmodule

/* hdl/wbuf_defs.svh */
// sizes for a 32-bit data path only; depth and slot count must be powers of two, at least 2
`ifndef WBUF_DEFS_SVH
`define WBUF_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// buffer geometry
//////////////////////////////////////////////////////////////////////

// number of word entries in the buffer
`define WBUF_DEPTH 4
// transaction slots, also the depth of the return ID FIFO
`define WBUF_MAX_TX 2

// data and physical address widths
`define WBUF_XLEN 32
`define WBUF_PLEN 32
// byte offset bits inside one data word
`define WBUF_ALIGN_BITS 2

`endif

/* hdl/wbuf_pkg.sv */
// types follow the sizes in wbuf_defs.svh; entry and slot layouts are packed structs
`include "wbuf_defs.svh"

package wbuf_pkg;

  // one data word and its byte enables
  typedef logic [`WBUF_XLEN-1:0]     word_data_t;
  typedef logic [`WBUF_XLEN/8-1:0]   byte_mask_t;

  // word address, byte offset stripped
  typedef logic [`WBUF_PLEN-`WBUF_ALIGN_BITS-1:0] wtag_t;

  // entry index and transaction ID
  typedef logic [$clog2(`WBUF_DEPTH)-1:0]  wbuf_ptr_t;
  typedef logic [$clog2(`WBUF_MAX_TX)-1:0] tx_id_t;

  // transfer size code on the memory side
  typedef logic [1:0] tx_size_t;
  localparam tx_size_t SIZE_BYTE = 2'd0;
  localparam tx_size_t SIZE_HALF = 2'd1;
  localparam tx_size_t SIZE_WORD = 2'd2;

  // per byte: valid/dirty/txblock
  typedef struct packed {
    wtag_t      wtag;
    word_data_t data;
    byte_mask_t valid;
    byte_mask_t dirty;
    byte_mask_t txblock;
  } wbuf_entry_t;

  // one outstanding transaction
  typedef struct packed {
    logic       vld;
    byte_mask_t be;
    wbuf_ptr_t  ptr;
  } tx_stat_t;

endpackage

/* hdl/wbuf_store.sv */
// coalesces on addr_i word address only; a granted write with all-zero be_i leaves its entry invalid
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_store (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // core write port
  input  logic                   data_req_i,
  input  logic [`WBUF_PLEN-1:0]  addr_i,
  input  wbuf_pkg::word_data_t   wdata_i,
  input  wbuf_pkg::byte_mask_t   be_i,
  output logic                   data_gnt_o,
  // bytes handed to memory this cycle
  input  logic                   send_i,
  input  wbuf_pkg::wbuf_ptr_t    send_ptr_i,
  input  wbuf_pkg::byte_mask_t   send_be_i,
  // bytes whose transfer has returned
  input  logic                   evict_i,
  input  wbuf_pkg::wbuf_ptr_t    evict_ptr_i,
  input  wbuf_pkg::byte_mask_t   evict_be_i,
  // state toward the send path
  output wbuf_pkg::wbuf_entry_t  entries_o [`WBUF_DEPTH],
  output logic [`WBUF_DEPTH-1:0] dirty_o,
  output logic                   empty_o
);
  import wbuf_pkg::*;

  localparam int unsigned nbytes = `WBUF_XLEN / 8;

  // payload, written on grant only
  wtag_t      wtag_q    [`WBUF_DEPTH];
  word_data_t data_q    [`WBUF_DEPTH];
  // byte state
  byte_mask_t valid_q   [`WBUF_DEPTH];
  byte_mask_t valid_d   [`WBUF_DEPTH];
  byte_mask_t dirty_q   [`WBUF_DEPTH];
  byte_mask_t dirty_d   [`WBUF_DEPTH];
  byte_mask_t txblock_q [`WBUF_DEPTH];
  byte_mask_t txblock_d [`WBUF_DEPTH];

  logic [`WBUF_DEPTH-1:0] entry_vld;
  logic [`WBUF_DEPTH-1:0] hit_oh;
  wbuf_ptr_t              hit_ptr;
  wbuf_ptr_t              free_ptr;
  wbuf_ptr_t              wr_ptr;
  logic                   full;
  logic                   wr_en;
  wtag_t                  req_wtag;

  //////////////////////////////////////////////////////////////////////
  // per-entry flags
  //////////////////////////////////////////////////////////////////////

  assign req_wtag = addr_i[`WBUF_PLEN-1:`WBUF_ALIGN_BITS];

  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : g_flags
    assign entry_vld[k] = |valid_q[k];
    // invalid entries never match, whatever their stale tag
    assign hit_oh[k]    = entry_vld[k] && (wtag_q[k] == req_wtag);
    // a word with bytes in flight is held back so transfers cannot overtake
    assign dirty_o[k]   = (|txblock_q[k]) ? 1'b0 : |(dirty_q[k] & valid_q[k]);
    assign entries_o[k] = '{
      wtag:    wtag_q[k],
      data:    data_q[k],
      valid:   valid_q[k],
      dirty:   dirty_q[k],
      txblock: txblock_q[k]
    };
  end

  // hit index and lowest free entry
  always_comb begin : p_search
    hit_ptr  = '0;
    free_ptr = '0;
    full     = 1'b1;
    // walking down leaves the lowest index behind
    for (int k = `WBUF_DEPTH - 1; k >= 0; k--) begin
      if (hit_oh[k]) begin
        hit_ptr = wbuf_ptr_t'(k);
      end
      if (!entry_vld[k]) begin
        free_ptr = wbuf_ptr_t'(k);
        full     = 1'b0;
      end
    end
  end

  assign wr_ptr     = (|hit_oh) ? hit_ptr : free_ptr;
  // a full buffer still takes writes to words it holds
  assign data_gnt_o = data_req_i && ((|hit_oh) || !full);
  assign wr_en      = data_gnt_o;
  assign empty_o    = ~|entry_vld;

  //////////////////////////////////////////////////////////////////////
  // byte state update: evict, then send, then write
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_update
    for (int k = 0; k < `WBUF_DEPTH; k++) begin
      valid_d[k]   = valid_q[k];
      dirty_d[k]   = dirty_q[k];
      txblock_d[k] = txblock_q[k];
    end

    // returned bytes leave flight; clean ones are gone, rewritten ones stay for resend
    if (evict_i) begin
      for (int b = 0; b < nbytes; b++) begin
        if (evict_be_i[b]) begin
          txblock_d[evict_ptr_i][b] = 1'b0;
          if (!dirty_q[evict_ptr_i][b]) begin
            valid_d[evict_ptr_i][b] = 1'b0;
          end
        end
      end
    end

    // bytes on the bus become in-flight
    if (send_i) begin
      for (int b = 0; b < nbytes; b++) begin
        if (send_be_i[b]) begin
          dirty_d[send_ptr_i][b]   = 1'b0;
          txblock_d[send_ptr_i][b] = 1'b1;
        end
      end
    end

    // new data; a byte in flight ends up 1/1/1
    if (wr_en) begin
      for (int b = 0; b < nbytes; b++) begin
        if (be_i[b]) begin
          valid_d[wr_ptr][b] = 1'b1;
          dirty_d[wr_ptr][b] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      for (int k = 0; k < `WBUF_DEPTH; k++) begin
        valid_q[k]   <= '0;
        dirty_q[k]   <= '0;
        txblock_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < `WBUF_DEPTH; k++) begin
        valid_q[k]   <= valid_d[k];
        dirty_q[k]   <= dirty_d[k];
        txblock_q[k] <= txblock_d[k];
      end
    end
  end

  // tag is rewritten on a hit with the same value
  always_ff @(posedge clk_i) begin : p_payload
    if (wr_en) begin
      wtag_q[wr_ptr] <= req_wtag;
      for (int b = 0; b < nbytes; b++) begin
        if (be_i[b]) begin
          data_q[wr_ptr][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

/* hdl/wbuf_top.sv */
// one core write and one memory transfer per cycle; returned IDs are never refused
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // core write port
  input  logic                  data_req_i,
  input  logic [`WBUF_PLEN-1:0] addr_i,
  input  wbuf_pkg::word_data_t  wdata_i,
  input  wbuf_pkg::byte_mask_t  be_i,
  output logic                  data_gnt_o,
  // memory write request
  output logic                  miss_req_o,
  input  logic                  miss_ack_i,
  output logic [`WBUF_PLEN-1:0] miss_paddr_o,
  output wbuf_pkg::tx_size_t    miss_size_o,
  output wbuf_pkg::word_data_t  miss_wdata_o,
  output wbuf_pkg::tx_id_t      miss_id_o,
  // memory write return
  input  logic                  rtrn_vld_i,
  input  wbuf_pkg::tx_id_t      rtrn_id_i,
  // status
  output logic                  empty_o
);
  import wbuf_pkg::*;

  wbuf_entry_t            entries [`WBUF_DEPTH];
  logic [`WBUF_DEPTH-1:0] dirty;
  wbuf_ptr_t              dirty_ptr;
  byte_mask_t             send_be;
  logic                   send;
  logic                   slot_free;
  logic                   evict;
  wbuf_ptr_t              evict_ptr;
  byte_mask_t             evict_be;

  // request whenever a word is sendable and an ID is available
  assign miss_req_o = (|dirty) && slot_free;
  assign send       = miss_req_o && miss_ack_i;

  wbuf_store i_wbuf_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .data_req_i  (data_req_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .be_i        (be_i),
    .data_gnt_o  (data_gnt_o),
    .send_i      (send),
    .send_ptr_i  (dirty_ptr),
    .send_be_i   (send_be),
    .evict_i     (evict),
    .evict_ptr_i (evict_ptr),
    .evict_be_i  (evict_be),
    .entries_o   (entries),
    .dirty_o     (dirty),
    .empty_o     (empty_o)
  );

  // dirty word to serve, held until memory takes it
  rr_arbiter #(
    .num_in (`WBUF_DEPTH)
  ) i_dirty_rr (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (dirty),
    .gnt_i  (send),
    .idx_o  (dirty_ptr)
  );

  tx_former i_tx_former (
    .entry_i (entries[dirty_ptr]),
    .paddr_o (miss_paddr_o),
    .size_o  (miss_size_o),
    .wdata_o (miss_wdata_o),
    .be_o    (send_be)
  );

  tx_tracker i_tx_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .send_i      (send),
    .send_ptr_i  (dirty_ptr),
    .send_be_i   (send_be),
    .rtrn_vld_i  (rtrn_vld_i),
    .rtrn_id_i   (rtrn_id_i),
    .slot_free_o (slot_free),
    .tx_id_o     (miss_id_o),
    .evict_o     (evict),
    .evict_ptr_o (evict_ptr),
    .evict_be_o  (evict_be)
  );

endmodule

/* testbench/tb_clk_gen.sv */
// free-running 10 ns clock; reset is released 1 ns after the rst_cycles-th rising edge
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned rst_cycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin : p_clk
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release away from the edge so no flop sees it mid-update
  initial begin : p_rst
    rst_no = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

/* testbench/tb_wbuf.sv */
// inputs change 1 ns after the rising edge; all table addresses lie in 0x1000..0x10ff
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module tb_wbuf;
  import wbuf_pkg::*;

  localparam int unsigned n_rows         = 19;
  localparam int unsigned timeout_cycles = n_rows * 40 + 200;

  // one core write and what should happen to it
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] data;
    logic        hold;
    logic        gnt;
  } stim_row_t;

  stim_row_t   stim [n_rows];
  logic        clk;
  logic        rst_n;
  logic        data_req;
  logic [31:0] addr;
  word_data_t  wdata;
  byte_mask_t  be;
  logic        data_gnt;
  logic        miss_req;
  logic        miss_ack;
  logic [31:0] miss_paddr;
  tx_size_t    miss_size;
  word_data_t  miss_wdata;
  tx_id_t      miss_id;
  logic        rtrn_vld;
  tx_id_t      rtrn_id;
  logic        empty;
  logic        no_gnt;
  logic        final_chk;
  logic        hold_rtrn;
  int unsigned mismatch_cnt;
  int unsigned proto_cnt;
  int unsigned cyc = 0;
  integer      seed = 59439;
  // pending returns, one per ID
  logic        pend_vld [`WBUF_MAX_TX];
  int unsigned pend_due [`WBUF_MAX_TX];

  tb_clk_gen i_tb_clk_gen (.clk_o(clk), .rst_no(rst_n));

  wbuf_top i_wbuf_top (
    .clk_i (clk), .rst_ni (rst_n),
    .data_req_i (data_req), .addr_i (addr), .wdata_i (wdata), .be_i (be),
    .data_gnt_o (data_gnt),
    .miss_req_o (miss_req), .miss_ack_i (miss_ack), .miss_paddr_o (miss_paddr),
    .miss_size_o (miss_size), .miss_wdata_o (miss_wdata), .miss_id_o (miss_id),
    .rtrn_vld_i (rtrn_vld), .rtrn_id_i (rtrn_id), .empty_o (empty)
  );

  tb_wbuf_monitor i_tb_wbuf_monitor (
    .clk_i (clk), .rst_ni (rst_n),
    .core_req_i (data_req), .core_addr_i (addr), .core_wdata_i (wdata),
    .core_be_i (be), .core_gnt_i (data_gnt),
    .miss_req_i (miss_req), .miss_ack_i (miss_ack), .miss_paddr_i (miss_paddr),
    .miss_size_i (miss_size), .miss_wdata_i (miss_wdata), .miss_id_i (miss_id),
    .rtrn_vld_i (rtrn_vld), .rtrn_id_i (rtrn_id), .empty_i (empty),
    .no_gnt_i (no_gnt), .final_chk_i (final_chk),
    .mismatch_cnt_o (mismatch_cnt), .proto_cnt_o (proto_cnt)
  );

  //////////////////////////////////////////////////////////////////////
  // stimulus table: addr, be, data, hold returns, expect grant
  //////////////////////////////////////////////////////////////////////

  initial begin : p_table
    // free-running returns, holes and rewrites
    stim[0]  = '{32'h0000_1000, 4'hf, 32'h1122_3344, 1'b0, 1'b1};
    stim[1]  = '{32'h0000_1004, 4'h1, 32'h0000_00a1, 1'b0, 1'b1};
    stim[2]  = '{32'h0000_1004, 4'h4, 32'h00b2_0000, 1'b0, 1'b1};
    stim[3]  = '{32'h0000_1008, 4'hc, 32'hc3c4_0000, 1'b0, 1'b1};
    stim[4]  = '{32'h0000_100c, 4'h6, 32'h00d5_d600, 1'b0, 1'b1};
    stim[5]  = '{32'h0000_1000, 4'h3, 32'h0000_e7e8, 1'b0, 1'b1};
    stim[6]  = '{32'h0000_1010, 4'h8, 32'hf900_0000, 1'b0, 1'b1};
    stim[7]  = '{32'h0000_1000, 4'hf, 32'h0a0b_0c0d, 1'b0, 1'b1};
    stim[8]  = '{32'h0000_1014, 4'hf, 32'h1234_5678, 1'b0, 1'b1};
    // returns held: fill all four entries, fifth word must wait
    stim[9]  = '{32'h0000_1020, 4'hf, 32'h2122_2324, 1'b1, 1'b1};
    stim[10] = '{32'h0000_1024, 4'h3, 32'h0000_3536, 1'b1, 1'b1};
    stim[11] = '{32'h0000_1028, 4'hc, 32'h4748_0000, 1'b1, 1'b1};
    stim[12] = '{32'h0000_102c, 4'h1, 32'h0000_0059, 1'b1, 1'b1};
    stim[13] = '{32'h0000_1030, 4'hf, 32'h6a6b_6c6d, 1'b1, 1'b0};
    stim[14] = '{32'h0000_1020, 4'h6, 32'h007e_7f00, 1'b1, 1'b1};
    stim[15] = '{32'h0000_1024, 4'hf, 32'h8a8b_8c8d, 1'b1, 1'b1};
    // returns released again
    stim[16] = '{32'h0000_1030, 4'hf, 32'h9a9b_9c9d, 1'b0, 1'b1};
    stim[17] = '{32'h0000_1020, 4'hf, 32'habac_adae, 1'b0, 1'b1};
    stim[18] = '{32'h0000_1004, 4'h9, 32'hbf00_00b0, 1'b0, 1'b1};
  end

  task automatic wait_empty();
    do @(negedge clk); while (!empty);
    @(posedge clk);
    #1;
  endtask

  // blocked rows hold the request for a while and are never written
  task automatic apply_row(input int unsigned r);
    logic granted;
    data_req = 1'b1;
    addr     = stim[r].addr;
    be       = stim[r].be;
    wdata    = stim[r].data;
    if (!stim[r].gnt) begin
      no_gnt = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      no_gnt = 1'b0;
    end else begin
      granted = 1'b0;
      while (!granted) begin
        @(negedge clk);
        granted = data_gnt;
        @(posedge clk);
        #1;
      end
    end
    data_req = 1'b0;
  endtask

  initial begin : p_main
    int unsigned total;
    data_req  = 1'b0;
    addr      = '0;
    wdata     = '0;
    be        = '0;
    miss_ack  = 1'b0;
    rtrn_vld  = 1'b0;
    rtrn_id   = '0;
    no_gnt    = 1'b0;
    final_chk = 1'b0;
    hold_rtrn = 1'b0;
    for (int k = 0; k < `WBUF_MAX_TX; k++) begin
      pend_vld[k] = 1'b0;
      pend_due[k] = 0;
    end
    @(posedge rst_n);
    repeat (3) @(posedge clk);
    #1;
    for (int unsigned r = 0; r < n_rows; r++) begin
      // a held phase starts from an empty buffer
      if (stim[r].hold && !hold_rtrn) wait_empty();
      hold_rtrn = stim[r].hold;
      apply_row(r);
    end
    hold_rtrn = 1'b0;
    wait_empty();
    final_chk = 1'b1;
    @(posedge clk);
    #1;
    total = mismatch_cnt + proto_cnt + i_wbuf_top.i_wbuf_store.i_wbuf_checker.fail_cnt;
    $display("errors: %0d mismatch, %0d protocol, %0d assertion", mismatch_cnt, proto_cnt,
             i_wbuf_top.i_wbuf_store.i_wbuf_checker.fail_cnt);
    if (total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // memory responder and cycle limit
  //////////////////////////////////////////////////////////////////////

  // accepted transfer returns 1 to 6 cycles later
  always @(negedge clk) begin : p_accept
    if (rst_n && miss_req && miss_ack) begin
      pend_vld[miss_id] = 1'b1;
      pend_due[miss_id] = cyc + 1 + ({$random(seed)} % 6);
    end
  end

  always @(posedge clk) begin : p_respond
    logic found;
    #1;
    found    = 1'b0;
    miss_ack = rst_n ? 1'($random(seed)) : 1'b0;
    rtrn_vld = 1'b0;
    if (!hold_rtrn) begin
      for (int k = 0; k < `WBUF_MAX_TX; k++) begin
        if (!found && pend_vld[k] && pend_due[k] <= cyc) begin
          found       = 1'b1;
          rtrn_vld    = 1'b1;
          rtrn_id     = tx_id_t'(k);
          pend_vld[k] = 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin : p_timeout
    cyc <= cyc + 1;
    if (cyc >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("sim failed");
      $finish;
    end
  end

endmodule

/* testbench/tb_wbuf_monitor.sv */
// samples on the falling edge; memory image covers one 256-byte region only
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module tb_wbuf_monitor #(
  parameter logic [31:0] region = 32'h0000_1000
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  core_req_i,
  input  logic [31:0]           core_addr_i,
  input  wbuf_pkg::word_data_t  core_wdata_i,
  input  wbuf_pkg::byte_mask_t  core_be_i,
  input  logic                  core_gnt_i,
  input  logic                  miss_req_i,
  input  logic                  miss_ack_i,
  input  logic [31:0]           miss_paddr_i,
  input  wbuf_pkg::tx_size_t    miss_size_i,
  input  wbuf_pkg::word_data_t  miss_wdata_i,
  input  wbuf_pkg::tx_id_t      miss_id_i,
  input  logic                  rtrn_vld_i,
  input  wbuf_pkg::tx_id_t      rtrn_id_i,
  input  logic                  empty_i,
  input  logic                  no_gnt_i,
  input  logic                  final_chk_i,
  output int unsigned           mismatch_cnt_o,
  output int unsigned           proto_cnt_o
);
  import wbuf_pkg::*;

  // what memory received vs. last value the core wrote
  logic [7:0]  mem_img  [256];
  logic [7:0]  exp_img  [256];
  logic        out_vld  [`WBUF_MAX_TX];
  wtag_t       out_wtag [`WBUF_MAX_TX];
  int unsigned after_rst;

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    mismatch_cnt_o++;
  endtask

  task automatic report_failure(input string msg);
    $display("error at %0t: %s", $time, msg);
    proto_cnt_o++;
  endtask

  initial begin : p_init
    mismatch_cnt_o = 0;
    proto_cnt_o    = 0;
    after_rst      = 0;
    for (int i = 0; i < 256; i++) begin
      mem_img[i] = fill_byte(region + i);
      exp_img[i] = fill_byte(region + i);
    end
    for (int k = 0; k < `WBUF_MAX_TX; k++) begin
      out_vld[k] = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // per-cycle checks
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : p_watch
    int unsigned off;
    int unsigned span;
    int unsigned n_out;
    logic        same_word;
    // idle outputs during reset and in the first cycle after it
    if (!rst_ni || after_rst == 0) begin
      if (core_gnt_i !== 1'b0) report_mismatch("data_gnt_o", core_gnt_i, 0);
      if (miss_req_i !== 1'b0) report_mismatch("miss_req_o", miss_req_i, 0);
      if (empty_i !== 1'b1) report_mismatch("empty_o", empty_i, 1);
    end
    if (rst_ni) begin
      after_rst++;
      // core writes build the expected image
      if (core_req_i && core_gnt_i) begin
        if (no_gnt_i) report_mismatch("data_gnt_o", 1, 0);
        for (int b = 0; b < 4; b++) begin
          if (core_be_i[b]) exp_img[{core_addr_i[7:2], 2'(b)}] = core_wdata_i[b*8 +: 8];
        end
      end
      if (miss_req_i && miss_ack_i) begin
        off  = miss_paddr_i[1:0];
        span = 1 << miss_size_i;
        n_out     = 0;
        same_word = 1'b0;
        for (int k = 0; k < `WBUF_MAX_TX; k++) begin
          if (out_vld[k]) begin
            n_out++;
            if (out_wtag[k] == miss_paddr_i[31:2]) same_word = 1'b1;
          end
        end
        if (out_vld[miss_id_i]) report_failure($sformatf("ID %0d reused before return", miss_id_i));
        if (n_out >= `WBUF_MAX_TX) report_failure("too many transfers outstanding");
        if (same_word) report_failure("two outstanding transfers to one word");
        out_vld[miss_id_i]  = 1'b1;
        out_wtag[miss_id_i] = miss_paddr_i[31:2];
        if (miss_paddr_i[31:8] != region[31:8]) begin
          report_failure("transfer address outside the written region");
        end else if (miss_size_i > SIZE_WORD) begin
          report_failure("illegal transfer size code");
        end else if ((off % span) != 0 || off + span > 4) begin
          report_failure("transfer span misaligned or crossing a word");
        end else begin
          // narrow data must repeat on every lane
          for (int b = 0; b < 4; b++) begin
            if (miss_wdata_i[b*8 +: 8] !== miss_wdata_i[(off + (b % span))*8 +: 8]) begin
              report_mismatch($sformatf("miss_wdata_o lane %0d", b), miss_wdata_i[b*8 +: 8],
                              miss_wdata_i[(off + (b % span))*8 +: 8]);
            end
          end
          for (int j = 0; j < span; j++) begin
            mem_img[miss_paddr_i[7:0] + j] = miss_wdata_i[(off + j)*8 +: 8];
          end
        end
      end
      // returns after sends, so a same-cycle reuse is still caught
      if (rtrn_vld_i) begin
        if (!out_vld[rtrn_id_i]) report_failure("returned ID was not outstanding");
        out_vld[rtrn_id_i] = 1'b0;
      end
    end
  end

  // final memory comparison once the buffer has drained
  always @(posedge final_chk_i) begin : p_final
    if (empty_i !== 1'b1) report_mismatch("empty_o", empty_i, 1);
    for (int i = 0; i < 256; i++) begin
      if (mem_img[i] !== exp_img[i]) begin
        report_mismatch($sformatf("mem[%h]", region + i), mem_img[i], exp_img[i]);
      end
    end
  end

endmodule

/* testbench/wbuf_checker.sv */
// bound into wbuf_store; relies on its internal name hit_oh and its ports addr_i and entries_o
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_checker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`WBUF_DEPTH-1:0] hit_oh_i,
  input  logic [`WBUF_PLEN-1:0]  addr_i,
  input  logic                   data_gnt_i,
  input  wbuf_pkg::wbuf_entry_t  entries_i [`WBUF_DEPTH]
);
  import wbuf_pkg::*;

  // assertion failures so far
  int unsigned fail_cnt = 0;
  logic        states_ok;
  logic        room;

  // legal v/d/t are 000, 110, 101, 111, so valid is exactly dirty or in flight
  always_comb begin : p_states
    states_ok = 1'b1;
    for (int k = 0; k < `WBUF_DEPTH; k++) begin
      if (entries_i[k].valid != (entries_i[k].dirty | entries_i[k].txblock)) begin
        states_ok = 1'b0;
      end
    end
  end

  // some entry already holds the requested word or has no valid byte
  always_comb begin : p_room
    room = 1'b0;
    for (int k = 0; k < `WBUF_DEPTH; k++) begin
      if (!(|entries_i[k].valid) ||
          (entries_i[k].wtag == addr_i[`WBUF_PLEN-1:`WBUF_ALIGN_BITS])) begin
        room = 1'b1;
      end
    end
  end

  a_hit_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_oh_i))
    else begin
      $error("more than one entry hits the same word");
      fail_cnt++;
    end

  a_byte_states : assert property (@(posedge clk_i) disable iff (!rst_ni) states_ok)
    else begin
      $error("a byte is in an illegal valid/dirty/txblock state");
      fail_cnt++;
    end

  a_gnt_room : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_gnt_i |-> room)
    else begin
      $error("write granted with no hit and no free entry");
      fail_cnt++;
    end

endmodule

bind wbuf_store wbuf_checker i_wbuf_checker (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .hit_oh_i   (hit_oh),
  .addr_i     (addr_i),
  .data_gnt_i (data_gnt_o),
  .entries_i  (entries_o)
);
